// ==== udp_rx_core.f ====
+incdir+include
logic/udp_rx_pkg.sv
logic/byte_stream_if.sv
logic/hdr_strip.sv
logic/udp_frame_filter.sv
logic/udp_rx_output.sv
logic/uart_byte_tx.sv
logic/udp_rx_core.sv
verification/udp_rx_core_properties.sv
verification/udp_rx_core_tb.sv

// ==== verification/udp_rx_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_config.svh"

module udp_rx_core_tb;

    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_TESTS  = 10;
    localparam logic [31:0] DST_IP = 32'hc0a8_0a64;

    typedef struct {
        string       name;
        logic [15:0] eth_type;
        logic [7:0]  ver_ihl;
        logic [7:0]  protocol;
        logic [47:0] src_mac;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        int          pay_len;
        int          trunc_len;
        bit          accept;
        bit          stall;
        bit          user_err;
    } test_row_t;

    // Truncation length 0 means the whole frame is sent
    // user_err flags a bad frame from the MAC on the last byte
    test_row_t tests [NUM_TESTS] = '{
        '{"basic_udp",      16'h0800, 8'h45, 8'd17, 48'h0211_2233_4455, 16'd1234, 16'd5678,
          16, 0, 1'b1, 1'b0, 1'b0},
        '{"bad_ethertype",  16'h86dd, 8'h45, 8'd17, 48'h0211_2233_4466, 16'd1, 16'd2,
          10, 0, 1'b0, 1'b0, 1'b0},
        '{"after_bad_type", 16'h0800, 8'h45, 8'd17, 48'h2020_0000_00aa, 16'd80, 16'd8080,
          8, 0, 1'b1, 1'b0, 1'b0},
        '{"bad_protocol",   16'h0800, 8'h45, 8'd6, 48'h0211_2233_4477, 16'd3, 16'd4,
          12, 0, 1'b0, 1'b0, 1'b0},
        '{"ihl_six",        16'h0800, 8'h46, 8'd17, 48'h0211_2233_4488, 16'd5, 16'd6,
          12, 0, 1'b0, 1'b0, 1'b0},
        '{"trunc_eth",      16'h0800, 8'h45, 8'd17, 48'h0211_2233_4499, 16'd7, 16'd8,
          6, 9, 1'b0, 1'b0, 1'b0},
        '{"trunc_ip",       16'h0800, 8'h45, 8'd17, 48'h0211_2233_44a0, 16'd9, 16'd10,
          6, 30, 1'b0, 1'b0, 1'b0},
        '{"after_trunc",    16'h0800, 8'h45, 8'd17, 48'h020a_0b0c_0d3c, 16'd53, 16'd4000,
          5, 0, 1'b1, 1'b0, 1'b1},
        '{"stall_match",    16'h0800, 8'h45, 8'd17, 48'h2020_0000_00aa, 16'd7777, 16'd9,
          40, 0, 1'b1, 1'b1, 1'b0},
        '{"stall_nomatch",  16'h0800, 8'h45, 8'd17, 48'h2020_0000_00ab, 16'd65535, 16'd1,
          23, 0, 1'b1, 1'b1, 1'b1}
    };

    logic        clk = 1'b0;
    logic        rst;
    logic [7:0]  rx_tdata;
    logic        rx_tvalid;
    logic        rx_tready;
    logic        rx_tlast;
    logic        rx_tuser;
    logic        udp_hdr_valid;
    logic        udp_hdr_ready;
    logic [47:0] udp_src_mac;
    logic [31:0] udp_src_ip;
    logic [31:0] udp_dst_ip;
    logic [15:0] udp_src_port;
    logic [15:0] udp_dst_port;
    logic [15:0] udp_length;
    logic [7:0]  payload_tdata;
    logic        payload_tvalid;
    logic        payload_tready;
    logic        payload_tlast;
    logic        payload_tuser;
    logic        mac_match;
    logic        uart_tx;

    logic [7:0]   frame_q[$];
    logic [7:0]   exp_pay_q[$];
    logic [159:0] hdr_q[$];
    logic [9:0]   pay_q[$];
    logic [7:0]   uart_q[$];
    logic         stall_on;
    logic         expected_match;

    udp_rx_core u_udp_rx_core (.*);

    always #2 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s %s expected %0h actual %0h", test_name, what,
                     expected, actual);
            abort_run("value check failed");
        end
    endtask

    task automatic next_drive_point();
        @(posedge clk);
        #0.5;
    endtask

    // Wire order, most significant byte first
    task automatic push_field(input logic [63:0] value, input int count);
        for (int i = count - 1; i >= 0; i--) begin
            frame_q.push_back(value[8*i +: 8]);
        end
    endtask

    task automatic build_frame(input int idx);
        logic [7:0] data;
        frame_q.delete();
        exp_pay_q.delete();
        push_field(48'h0200_0000_0001, 6);
        push_field(tests[idx].src_mac, 6);
        push_field(tests[idx].eth_type, 2);
        push_field(tests[idx].ver_ihl, 1);
        push_field(8'h00, 1);
        push_field(28 + tests[idx].pay_len, 2);
        push_field(16'h1c46, 2);
        push_field(16'h4000, 2);
        push_field(8'h40, 1);
        push_field(tests[idx].protocol, 1);
        push_field(16'h0000, 2);
        push_field(32'hc0a8_0a00 + idx, 4);
        push_field(DST_IP, 4);
        push_field(tests[idx].src_port, 2);
        push_field(tests[idx].dst_port, 2);
        push_field(8 + tests[idx].pay_len, 2);
        push_field(16'h0000, 2);
        for (int i = 0; i < tests[idx].pay_len; i++) begin
            data = 8'($urandom);
            frame_q.push_back(data);
            exp_pay_q.push_back(data);
        end
        if (tests[idx].trunc_len > 0) begin
            while (frame_q.size() > tests[idx].trunc_len) begin
                void'(frame_q.pop_back());
            end
        end
    endtask

    task automatic send_frame(input bit user_err);
        int cnt;
        for (int i = 0; i < frame_q.size(); i++) begin
            rx_tdata  = frame_q[i];
            rx_tvalid = 1'b1;
            rx_tlast  = (i == frame_q.size() - 1);
            rx_tuser  = user_err && rx_tlast;
            cnt = 0;
            @(negedge clk);
            while (!rx_tready) begin
                cnt++;
                if (cnt > WAIT_LIMIT) begin
                    abort_run("rx_tready stayed low and the DUT stopped taking frame bytes");
                end
                @(negedge clk);
            end
            next_drive_point();
        end
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
        rx_tuser  = 1'b0;
        rx_tdata  = 8'h00;
    endtask

    task automatic check_accepted(input int idx);
        int cnt;
        string nm;
        nm = tests[idx].name;
        cnt = 0;
        while (pay_q.size() < tests[idx].pay_len) begin
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                abort_run({"payload of ", nm, " did not come out in time"});
            end
            @(negedge clk);
        end
        check_value(nm, "header count", 1, hdr_q.size());
        check_value(nm, "src_mac", tests[idx].src_mac, hdr_q[0][159:112]);
        check_value(nm, "src_ip", 32'hc0a8_0a00 + idx, hdr_q[0][111:80]);
        check_value(nm, "dst_ip", DST_IP, hdr_q[0][79:48]);
        check_value(nm, "src_port", tests[idx].src_port, hdr_q[0][47:32]);
        check_value(nm, "dst_port", tests[idx].dst_port, hdr_q[0][31:16]);
        check_value(nm, "udp_length", 8 + tests[idx].pay_len, hdr_q[0][15:0]);
        for (int i = 0; i < tests[idx].pay_len; i++) begin
            check_value(nm, $sformatf("payload byte %0d", i), exp_pay_q[i], pay_q[i][7:0]);
            check_value(nm, $sformatf("tlast at %0d", i), i == tests[idx].pay_len - 1,
                        pay_q[i][8]);
            check_value(nm, $sformatf("tuser at %0d", i),
                        tests[idx].user_err && (i == tests[idx].pay_len - 1), pay_q[i][9]);
        end
        expected_match = (tests[idx].src_mac == `UDP_RX_MATCH_MAC);
        check_value(nm, "mac_match", expected_match, mac_match);
        cnt = 0;
        while (uart_q.size() == 0) begin
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                abort_run({"no UART byte was sent after ", nm});
            end
            @(negedge clk);
        end
        check_value(nm, "uart byte", tests[idx].src_mac[7:0], uart_q.pop_front());
    endtask

    task automatic check_rejected(input int idx);
        // Longer than one UART byte, so a wrongly started send shows up too
        for (int i = 0; i < 120; i++) begin
            @(negedge clk);
        end
        check_value(tests[idx].name, "header count", 0, hdr_q.size());
        check_value(tests[idx].name, "payload count", 0, pay_q.size());
        check_value(tests[idx].name, "uart count", 0, uart_q.size());
        check_value(tests[idx].name, "mac_match", expected_match, mac_match);
    endtask

    // Ready stalls change a little after the edge like all other inputs
    always @(posedge clk) begin : ready_stalls
        logic stall_now;
        stall_now = stall_on;
        #0.5;
        if (stall_now) begin
            udp_hdr_ready  = ($urandom % 3) == 0;
            payload_tready = ($urandom % 2) == 0;
        end else begin
            udp_hdr_ready  = 1'b1;
            payload_tready = 1'b1;
        end
    end

    // Transfers seen at the falling edge happen at the next rising edge
    always @(negedge clk) begin
        if (!rst && udp_hdr_valid && udp_hdr_ready) begin
            hdr_q.push_back({udp_src_mac, udp_src_ip, udp_dst_ip, udp_src_port,
                             udp_dst_port, udp_length});
        end
        if (!rst && payload_tvalid && payload_tready) begin
            pay_q.push_back({payload_tuser, payload_tlast, payload_tdata});
        end
    end

    always @(posedge clk) begin
        if (u_udp_rx_core.u_props.fail_count != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end
    end

    // Serial decoder sampling in the middle of each bit
    initial begin : uart_decoder
        logic [7:0] rx_byte;
        forever begin
            @(negedge clk);
            if (!rst && uart_tx === 1'b0) begin
                repeat (`UDP_RX_UART_CLKS_PER_BIT / 2) @(negedge clk);
                if (uart_tx !== 1'b0) begin
                    abort_run("UART start bit was shorter than half a bit");
                end
                for (int b = 0; b < 8; b++) begin
                    repeat (`UDP_RX_UART_CLKS_PER_BIT) @(negedge clk);
                    rx_byte[b] = uart_tx;
                end
                repeat (`UDP_RX_UART_CLKS_PER_BIT) @(negedge clk);
                if (uart_tx !== 1'b1) begin
                    abort_run("UART stop bit was not high");
                end
                uart_q.push_back(rx_byte);
            end
        end
    end

    initial begin
        void'($urandom(41580));
        rst            = 1'b1;
        rx_tdata       = 8'h00;
        rx_tvalid      = 1'b0;
        rx_tlast       = 1'b0;
        rx_tuser       = 1'b0;
        udp_hdr_ready  = 1'b1;
        payload_tready = 1'b1;
        stall_on       = 1'b0;
        expected_match = 1'b0;
        repeat (16) @(posedge clk);
        #0.5;
        rst = 1'b0;
        @(negedge clk);
        check_value("reset", "udp_hdr_valid", 0, udp_hdr_valid);
        check_value("reset", "payload_tvalid", 0, payload_tvalid);
        check_value("reset", "mac_match", 0, mac_match);
        check_value("reset", "uart_tx", 1, uart_tx);
        check_value("reset", "rx_tready", 1, rx_tready);
        for (int t = 0; t < NUM_TESTS; t++) begin
            next_drive_point();
            build_frame(t);
            stall_on = tests[t].stall;
            send_frame(tests[t].user_err);
            if (tests[t].accept) begin
                check_accepted(t);
            end else begin
                check_rejected(t);
            end
            stall_on = 1'b0;
            hdr_q.delete();
            pay_q.delete();
        end
        if (u_udp_rx_core.u_props.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run("a bound assertion on the DUT failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== verification/udp_rx_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protocol rules on the top-level ports of the receive path
module udp_rx_core_properties (
    input logic        clk,
    input logic        rst,
    input logic        udp_hdr_valid,
    input logic        udp_hdr_ready,
    input logic [47:0] udp_src_mac,
    input logic [31:0] udp_src_ip,
    input logic [31:0] udp_dst_ip,
    input logic [15:0] udp_src_port,
    input logic [15:0] udp_dst_port,
    input logic [15:0] udp_length,
    input logic        payload_tvalid,
    input logic        uart_tx
);

    int fail_count = 0;

    // Header and its fields hold while the user stalls
    property hdr_held_p;
        @(posedge clk) disable iff (rst)
        (udp_hdr_valid && !udp_hdr_ready) |=> (udp_hdr_valid && $stable({udp_src_mac,
            udp_src_ip, udp_dst_ip, udp_src_port, udp_dst_port, udp_length}));
    endproperty

    // Payload waits for its header
    property no_payload_before_hdr_p;
        @(posedge clk) disable iff (rst)
        udp_hdr_valid |-> !payload_tvalid;
    endproperty

    // Serial line idles high in reset
    property uart_idle_in_reset_p;
        @(posedge clk)
        ($past(rst) && rst) |-> uart_tx;
    endproperty

    a_hdr_held: assert property (hdr_held_p) else begin
        $error("UDP header changed or dropped while udp_hdr_ready was low");
        fail_count++;
    end

    a_no_payload_before_hdr: assert property (no_payload_before_hdr_p) else begin
        $error("payload_tvalid high while the UDP header is pending");
        fail_count++;
    end

    a_uart_idle_in_reset: assert property (uart_idle_in_reset_p) else begin
        $error("uart_tx low during reset");
        fail_count++;
    end

endmodule

bind udp_rx_core udp_rx_core_properties u_props (
    .clk            (clk),
    .rst            (rst),
    .udp_hdr_valid  (udp_hdr_valid),
    .udp_hdr_ready  (udp_hdr_ready),
    .udp_src_mac    (udp_src_mac),
    .udp_src_ip     (udp_src_ip),
    .udp_dst_ip     (udp_dst_ip),
    .udp_src_port   (udp_src_port),
    .udp_dst_port   (udp_dst_port),
    .udp_length     (udp_length),
    .payload_tvalid (payload_tvalid),
    .uart_tx        (uart_tx)
);

`default_nettype wire

// ==== logic/udp_rx_core.sv ====
`timescale 1ns/1ps
`default_nettype none

// Receive path: Ethernet header, IPv4/UDP header, filter, user outputs
module udp_rx_core
    import udp_rx_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  rx_tdata,
    input  logic        rx_tvalid,
    output logic        rx_tready,
    input  logic        rx_tlast,
    input  logic        rx_tuser,
    output logic        udp_hdr_valid,
    input  logic        udp_hdr_ready,
    output mac_addr_t   udp_src_mac,
    output ip_addr_t    udp_src_ip,
    output ip_addr_t    udp_dst_ip,
    output logic [15:0] udp_src_port,
    output logic [15:0] udp_dst_port,
    output logic [15:0] udp_length,
    output logic [7:0]  payload_tdata,
    output logic        payload_tvalid,
    input  logic        payload_tready,
    output logic        payload_tlast,
    output logic        payload_tuser,
    output logic        mac_match,
    output logic        uart_tx
);

    byte_stream_if rx_bs ();
    byte_stream_if eth_pay ();
    byte_stream_if ip_pay ();
    byte_stream_if udp_pay ();

    eth_hdr_t    eth_hdr;
    logic        eth_valid;
    ip_udp_hdr_t ip_hdr;
    logic        ip_valid;
    udp_meta_t   meta;
    logic        meta_valid;
    logic        meta_ready;
    logic        uart_send;
    logic [7:0]  uart_byte;
    logic        uart_busy;

    assign rx_bs.tdata  = rx_tdata;
    assign rx_bs.tvalid = rx_tvalid;
    assign rx_bs.tlast  = rx_tlast;
    assign rx_bs.tuser  = rx_tuser;
    assign rx_tready    = rx_bs.tready;

    hdr_strip #(.hdr_t(eth_hdr_t)) u_eth_strip (
        .clk       (clk),
        .rst       (rst),
        .in        (rx_bs.sink),
        .out       (eth_pay.source),
        .hdr       (eth_hdr),
        .hdr_valid (eth_valid)
    );

    hdr_strip #(.hdr_t(ip_udp_hdr_t)) u_ip_strip (
        .clk       (clk),
        .rst       (rst),
        .in        (eth_pay.sink),
        .out       (ip_pay.source),
        .hdr       (ip_hdr),
        .hdr_valid (ip_valid)
    );

    udp_frame_filter u_filter (
        .clk        (clk),
        .rst        (rst),
        .eth_hdr    (eth_hdr),
        .eth_valid  (eth_valid),
        .ip_hdr     (ip_hdr),
        .ip_valid   (ip_valid),
        .in         (ip_pay.sink),
        .meta       (meta),
        .meta_valid (meta_valid),
        .meta_ready (meta_ready),
        .out        (udp_pay.source)
    );

    udp_rx_output u_output (
        .clk            (clk),
        .rst            (rst),
        .meta           (meta),
        .meta_valid     (meta_valid),
        .meta_ready     (meta_ready),
        .in             (udp_pay.sink),
        .udp_hdr_valid  (udp_hdr_valid),
        .udp_hdr_ready  (udp_hdr_ready),
        .udp_src_mac    (udp_src_mac),
        .udp_src_ip     (udp_src_ip),
        .udp_dst_ip     (udp_dst_ip),
        .udp_src_port   (udp_src_port),
        .udp_dst_port   (udp_dst_port),
        .udp_length     (udp_length),
        .payload_tdata  (payload_tdata),
        .payload_tvalid (payload_tvalid),
        .payload_tready (payload_tready),
        .payload_tlast  (payload_tlast),
        .payload_tuser  (payload_tuser),
        .mac_match      (mac_match),
        .uart_busy      (uart_busy),
        .uart_send      (uart_send),
        .uart_byte      (uart_byte)
    );

    uart_byte_tx u_uart (
        .clk  (clk),
        .rst  (rst),
        .send (uart_send),
        .data (uart_byte),
        .busy (uart_busy),
        .tx   (uart_tx)
    );

endmodule

`default_nettype wire

// ==== logic/uart_byte_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_config.svh"

// 8N1 transmitter, one byte per send strobe
module uart_byte_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       send,
    input  logic [7:0] data,
    output logic       busy,
    output logic       tx
);

    localparam int CLKS  = `UDP_RX_UART_CLKS_PER_BIT;
    localparam int CLK_W = $clog2(CLKS + 1);

    logic [CLK_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    // Data bits with the stop bit above them
    logic [8:0]       shift_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            tx      <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (send) begin
                busy    <= 1'b1;
                tx      <= 1'b0;
                shift_q <= {1'b1, data};
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == CLK_W'(CLKS - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                // Stop bit done, line stays high
                busy <= 1'b0;
            end else begin
                tx      <= shift_q[0];
                shift_q <= {1'b1, shift_q[8:1]};
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/udp_rx_output.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_config.svh"

// Header handshake toward the user, payload gate, MAC match and UART kick
module udp_rx_output
    import udp_rx_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  udp_meta_t   meta,
    input  logic        meta_valid,
    output logic        meta_ready,
    byte_stream_if.sink in,
    output logic        udp_hdr_valid,
    input  logic        udp_hdr_ready,
    output mac_addr_t   udp_src_mac,
    output ip_addr_t    udp_src_ip,
    output ip_addr_t    udp_dst_ip,
    output logic [15:0] udp_src_port,
    output logic [15:0] udp_dst_port,
    output logic [15:0] udp_length,
    output logic [7:0]  payload_tdata,
    output logic        payload_tvalid,
    input  logic        payload_tready,
    output logic        payload_tlast,
    output logic        payload_tuser,
    output logic        mac_match,
    input  logic        uart_busy,
    output logic        uart_send,
    output logic [7:0]  uart_byte
);

    udp_meta_t meta_q;
    logic      pay_open;
    logic      hdr_fire;
    logic      pay_fire;

    // New record only when no frame is in flight
    assign meta_ready = !udp_hdr_valid && !pay_open;
    assign hdr_fire   = udp_hdr_valid && udp_hdr_ready;

    assign udp_src_mac  = meta_q.src_mac;
    assign udp_src_ip   = meta_q.src_ip;
    assign udp_dst_ip   = meta_q.dst_ip;
    assign udp_src_port = meta_q.src_port;
    assign udp_dst_port = meta_q.dst_port;
    assign udp_length   = meta_q.udp_length;

    assign payload_tdata  = in.tdata;
    assign payload_tvalid = in.tvalid && pay_open;
    assign payload_tlast  = in.tlast;
    assign payload_tuser  = in.tuser;
    assign in.tready      = pay_open && payload_tready;

    assign pay_fire = payload_tvalid && payload_tready;

    always_ff @(posedge clk) begin
        if (meta_valid && meta_ready) begin
            meta_q <= meta;
        end
        if (hdr_fire) begin
            uart_byte <= meta_q.src_mac[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            udp_hdr_valid <= 1'b0;
            pay_open      <= 1'b0;
            mac_match     <= 1'b0;
            uart_send     <= 1'b0;
        end else begin
            uart_send <= hdr_fire && !uart_busy;
            if (meta_valid && meta_ready) begin
                udp_hdr_valid <= 1'b1;
            end else if (hdr_fire) begin
                udp_hdr_valid <= 1'b0;
                pay_open      <= 1'b1;
                mac_match     <= (meta_q.src_mac == `UDP_RX_MATCH_MAC);
            end else if (pay_fire && in.tlast) begin
                pay_open <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/udp_frame_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_config.svh"

// Accepts IPv4/UDP frames without options, drains everything else
module udp_frame_filter
    import udp_rx_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  eth_hdr_t      eth_hdr,
    input  logic          eth_valid,
    input  ip_udp_hdr_t   ip_hdr,
    input  logic          ip_valid,
    byte_stream_if.sink   in,
    output udp_meta_t     meta,
    output logic          meta_valid,
    input  logic          meta_ready,
    byte_stream_if.source out
);

    logic both_valid;
    logic frame_ok;
    logic meta_done;
    logic in_fire;

    assign both_valid = eth_valid && ip_valid;

    assign frame_ok = (eth_hdr.eth_type == `UDP_RX_ETHERTYPE_IPV4) &&
                      (ip_hdr.version == 4'd4) &&
                      (ip_hdr.ihl == 4'd5) &&
                      (ip_hdr.protocol == `UDP_RX_IP_PROTO_UDP);

    always_comb begin
        meta.src_mac    = eth_hdr.src_mac;
        meta.src_ip     = ip_hdr.src_ip;
        meta.dst_ip     = ip_hdr.dst_ip;
        meta.src_port   = ip_hdr.src_port;
        meta.dst_port   = ip_hdr.dst_port;
        meta.udp_length = ip_hdr.udp_length;
    end

    // One metadata record per accepted frame
    assign meta_valid = both_valid && frame_ok && !meta_done;

    // Payload only after the record has been taken
    assign out.tdata  = in.tdata;
    assign out.tvalid = in.tvalid && both_valid && frame_ok && meta_done;
    assign out.tlast  = in.tlast;
    assign out.tuser  = in.tuser;

    // Rejected frames are swallowed at full rate
    assign in.tready = both_valid && (frame_ok ? (meta_done && out.tready) : 1'b1);

    assign in_fire = in.tvalid && in.tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_done <= 1'b0;
        end else if (in_fire && in.tlast) begin
            meta_done <= 1'b0;
        end else if (meta_valid && meta_ready) begin
            meta_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/hdr_strip.sv ====
`timescale 1ns/1ps
`default_nettype none

// Collects a fixed-size header from the front of each frame, then
// passes the rest of the frame through unchanged
module hdr_strip
    import udp_rx_pkg::*;
#(
    parameter type hdr_t = eth_hdr_t
) (
    input  logic          clk,
    input  logic          rst,
    byte_stream_if.sink   in,
    byte_stream_if.source out,
    output hdr_t          hdr,
    output logic          hdr_valid
);

    localparam int HDR_W     = $bits(hdr_t);
    localparam int HDR_BYTES = HDR_W / 8;
    localparam int CNT_W     = $clog2(HDR_BYTES);

    logic [HDR_W-1:0] shift_q;
    logic [CNT_W-1:0] byte_cnt;
    logic             in_fire;

    assign in_fire = in.tvalid && in.tready;

    // Always ready while collecting, follow downstream once the header is held
    assign in.tready = hdr_valid ? out.tready : 1'b1;

    assign out.tdata  = in.tdata;
    assign out.tvalid = in.tvalid && hdr_valid;
    assign out.tlast  = in.tlast;
    assign out.tuser  = in.tuser;

    assign hdr = hdr_t'(shift_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt  <= '0;
            hdr_valid <= 1'b0;
        end else if (hdr_valid) begin
            // Header released once the frame's last byte leaves
            if (in_fire && in.tlast) begin
                hdr_valid <= 1'b0;
            end
        end else if (in_fire) begin
            if (in.tlast) begin
                // Too short for a header plus payload, forget it
                byte_cnt <= '0;
            end else if (byte_cnt == CNT_W'(HDR_BYTES - 1)) begin
                byte_cnt  <= '0;
                hdr_valid <= 1'b1;
            end else begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // First byte ends up in the MSBs, matching wire order of hdr_t
    always_ff @(posedge clk) begin
        if (!hdr_valid && in_fire) begin
            shift_q <= {shift_q[HDR_W-9:0], in.tdata};
        end
    end

endmodule

`default_nettype wire

// ==== logic/byte_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Byte-wide valid/ready stream with frame end and bad-frame flag
interface byte_stream_if;

    logic [7:0] tdata;
    logic       tvalid;
    logic       tready;
    logic       tlast;
    logic       tuser;

    modport source (
        output tdata, tvalid, tlast, tuser,
        input  tready
    );

    modport sink (
        input  tdata, tvalid, tlast, tuser,
        output tready
    );

endinterface

`default_nettype wire

// ==== logic/udp_rx_pkg.sv ====
`default_nettype none

package udp_rx_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    // Ethernet header, first byte on the wire in the MSBs
    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // IPv4 header without options, then the UDP header
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  dscp_ecn;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_checksum;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
    } ip_udp_hdr_t;

    // Fields presented with the UDP header handshake
    typedef struct packed {
        mac_addr_t   src_mac;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_length;
    } udp_meta_t;

endpackage

`default_nettype wire

// ==== include/udp_rx_config.svh ====
`ifndef UDP_RX_CONFIG_SVH
`define UDP_RX_CONFIG_SVH

// EtherType carried by IPv4 frames
`define UDP_RX_ETHERTYPE_IPV4 16'h0800

// IP protocol number for UDP
`define UDP_RX_IP_PROTO_UDP 8'd17

// Source MAC that lights the match output
`define UDP_RX_MATCH_MAC 48'h2020_0000_00aa

// Clock cycles per serial bit
`define UDP_RX_UART_CLKS_PER_BIT 8

`endif
